/* include/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//////////////////////////////////////////////////////////////////////
// ADC sample path
//////////////////////////////////////////////////////////////////////

`define SOC_DATA_W          32   // Sample and frame payload width
`define SOC_FLAG_W          4    // sof, eof and two spare bits
`define SOC_FIFO_DEPTH_LOG2 9    // 512 sample buffer
`define SOC_PACKET_WORDS    128  // Words per outgoing packet

//////////////////////////////////////////////////////////////////////
// VHDCI mux link
//////////////////////////////////////////////////////////////////////

`define SOC_MUX_W           8

// Training patterns
`define SOC_SYNC_HUNT       8'h01
`define SOC_SYNC_LOCK       8'h81

`endif

/* src/soc_pkg.sv */
`include "soc_cfg.svh"

package soc_pkg;

	// One ADC sample, two 16-bit channels packed
	typedef logic [`SOC_DATA_W-1:0] sample_t;

	// Flag nibble of the 36-bit frame bus, sof in bit 0
	typedef struct packed {
		logic [`SOC_FLAG_W-3:0] rsvd; // Always zero
		logic                   eof;
		logic                   sof;
	} frame_flags_t;

	typedef struct packed {
		frame_flags_t flags;
		sample_t      data;
	} frame_word_t;

	typedef enum logic {LINK_HUNT, LINK_LOCKED} link_state_e;

	typedef logic [`SOC_MUX_W-1:0] mux_word_t;

endpackage

/* src/frame_if.sv */
`timescale 1ns/1ps

// Frame bus with ready/ready handshake
interface frame_if (
	input logic clk_i
);
	soc_pkg::frame_word_t word;
	logic src_rdy; // Word is valid
	logic dst_rdy; // Consumer can take it

	// Framer side
	modport source (input clk_i, input dst_rdy, output word, output src_rdy);

	// Consumer side
	modport sink (input clk_i, input word, input src_rdy, output dst_rdy);

endinterface

/* src/adc_sample_fifo.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module adc_sample_fifo (
	input  logic             GMII_GTX_CLK_int,
	input  logic             dsp_rst,
	input  soc_pkg::sample_t data_i,
	input  logic             we_i,
	input  logic             pop_i,
	output soc_pkg::sample_t head_o,
	output logic             empty_o,
	output logic             pkt_avail_o
);

	localparam int AW    = `SOC_FIFO_DEPTH_LOG2;
	localparam int CW    = AW + 1;
	localparam int DEPTH = 1 << AW;

	soc_pkg::sample_t mem [DEPTH];
	logic [AW-1:0]    wr_ptr_q;
	logic [AW-1:0]    rd_ptr_q;
	logic [CW-1:0]    count_q; // Occupancy, 0 to DEPTH
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full    = (count_q == CW'(DEPTH));
	assign empty_o = (count_q == '0);
	assign do_wr   = we_i && !full; // Overflow drops the sample
	assign do_rd   = pop_i && !empty_o;

	// First word falls through
	assign head_o = mem[rd_ptr_q];

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (do_wr) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
			count_q     <= '0;
			pkt_avail_o <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at DEPTH
			end
			if (do_rd) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CW'(do_wr) - CW'(do_rd);
			// Lags the count by one cycle
			pkt_avail_o <= (count_q >= CW'(`SOC_PACKET_WORDS));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Framer only pops what it has seen at the head
	a_no_pop_empty: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		!(pop_i && empty_o))
		else $error("Pop from empty sample FIFO");

	// ADC source outran the framer
	a_no_write_full: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		!(we_i && full))
		else $error("ADC sample dropped, FIFO full");

endmodule

/* src/packet_framer.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module packet_framer (
	input  logic             GMII_GTX_CLK_int,
	input  logic             dsp_rst,
	input  soc_pkg::sample_t head_i,
	input  logic             empty_i,
	input  logic             pkt_avail_i,
	output logic             pop_o,
	frame_if.source          tx
);

	localparam int CNT_W = $clog2(`SOC_PACKET_WORDS);
	localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`SOC_PACKET_WORDS - 1);

	logic                 busy_q;    // Packet in progress
	logic [CNT_W-1:0]     cnt_q;     // Index of the next word to load
	logic                 src_rdy_q;
	soc_pkg::frame_word_t word_q;
	logic                 accept;
	logic                 reg_free;
	logic                 load;
	logic                 last;

	assign accept   = src_rdy_q && tx.dst_rdy;
	assign reg_free = !src_rdy_q || accept; // Refill on the accepting edge
	assign last     = (cnt_q == LAST_IDX);

	// Idle waits for a whole packet, busy takes whatever the head offers
	assign load  = (busy_q || pkt_avail_i) && reg_free && !empty_i;
	assign pop_o = load;

	assign tx.word    = word_q;
	assign tx.src_rdy = src_rdy_q;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			busy_q    <= 1'b0;
			cnt_q     <= '0;
			src_rdy_q <= 1'b0;
		end else if (load) begin
			busy_q    <= !last;
			cnt_q     <= last ? '0 : cnt_q + 1'b1;
			src_rdy_q <= 1'b1;
		end else if (accept) begin
			src_rdy_q <= 1'b0; // Drained, nothing behind it yet
		end
	end

	// Payload register
	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (load) begin
			word_q.data       <= head_i;
			word_q.flags.sof  <= (cnt_q == '0);
			word_q.flags.eof  <= last;
			word_q.flags.rsvd <= '0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Consumer stall must not disturb the offered word
	a_stall_stable: assert property (@(posedge tx.clk_i) disable iff (dsp_rst)
		(tx.src_rdy && !tx.dst_rdy) |=> (tx.src_rdy && $stable(tx.word)))
		else $error("Frame word changed while stalled");

endmodule

/* src/mux_link_sync.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module mux_link_sync (
	input  logic                  GMII_GTX_CLK_int,
	input  logic                  dsp_rst,
	input  soc_pkg::mux_word_t    mux_in_i,
	input  logic [`SOC_MUX_W-2:0] sw_i,
	output soc_pkg::mux_word_t    mux_out_o,
	output logic                  bitslip_o,
	output logic                  synced_o
);

	localparam int HB = `SOC_MUX_W - 1; // Heartbeat bit position
	localparam soc_pkg::mux_word_t PAT_HUNT = `SOC_SYNC_HUNT;
	localparam soc_pkg::mux_word_t PAT_LOCK = `SOC_SYNC_LOCK;

	soc_pkg::link_state_e state_q;
	soc_pkg::mux_word_t   pattern_q;    // Training word sent while hunting
	logic                 hb_q;
	logic                 mon_expect_q; // Next heartbeat from the partner
	logic                 mon_valid_q;
	logic                 bitslip_q;
	logic                 bitslip_d1_q; // Keeps pulses two cycles apart
	logic                 rx_good;
	logic                 rx_lock;

	assign rx_lock = (mux_in_i == PAT_LOCK);
	assign rx_good = rx_lock || (mux_in_i == PAT_HUNT);

	assign synced_o  = (state_q == soc_pkg::LINK_LOCKED);
	assign bitslip_o = bitslip_q;
	assign mux_out_o = synced_o ? {hb_q, sw_i} : pattern_q;

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (dsp_rst) begin
			state_q      <= soc_pkg::LINK_HUNT;
			pattern_q    <= PAT_HUNT;
			hb_q         <= 1'b0;
			mon_expect_q <= 1'b0;
			mon_valid_q  <= 1'b0;
			bitslip_q    <= 1'b0;
			bitslip_d1_q <= 1'b0;
		end else begin
			hb_q         <= !hb_q; // Partner watches this for link loss
			bitslip_q    <= 1'b0;
			bitslip_d1_q <= bitslip_q;
			case (state_q)
				soc_pkg::LINK_HUNT: begin
					if (!rx_good) begin
						pattern_q   <= PAT_HUNT;
						mon_valid_q <= 1'b0;
						if (!bitslip_q && !bitslip_d1_q) begin
							bitslip_q <= 1'b1;
						end
					end else begin
						// Both ends agree on 0x81
						if (rx_lock && pattern_q == PAT_LOCK) begin
							state_q <= soc_pkg::LINK_LOCKED;
						end
						pattern_q <= PAT_LOCK;
					end
				end
				soc_pkg::LINK_LOCKED: begin
					if (mon_valid_q) begin
						if (mux_in_i[HB] == mon_expect_q) begin
							mon_expect_q <= !mux_in_i[HB];
						end else begin
							mon_valid_q <= 1'b0;
							state_q     <= soc_pkg::LINK_HUNT; // Heartbeat lost
						end
					end else if (!rx_lock) begin
						// Partner left training, start watching
						mon_expect_q <= !mux_in_i[HB];
						mon_valid_q  <= 1'b1;
					end
				end
				default: state_q <= soc_pkg::LINK_HUNT;
			endcase
		end
	end

	a_no_slip_locked: assert property (@(posedge GMII_GTX_CLK_int) disable iff (dsp_rst)
		synced_o |-> !bitslip_o)
		else $error("Bitslip pulse while link locked");

endmodule

/* src/soc_top.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_top (
	input  logic                  GMII_GTX_CLK_int,
	input  logic                  dsp_rst,
	// ADC samples, already deserialized
	input  logic [`SOC_DATA_W-1:0] adc_data_i,
	input  logic                  adc_data_we_i,
	// Frame output
	input  logic                  tx_dst_rdy_i,
	output logic [`SOC_DATA_W-1:0] tx_data_o,
	output logic                  tx_sof_o,
	output logic                  tx_eof_o,
	output logic                  tx_src_rdy_o,
	// VHDCI mux link
	input  logic [`SOC_MUX_W-1:0] mux_in_i,
	input  logic [`SOC_MUX_W-2:0] sw_i,
	output logic [`SOC_MUX_W-1:0] mux_out_o,
	output logic                  mux_bitslip_o,
	output logic                  mux_synced_o
);

	soc_pkg::sample_t fifo_head;
	logic             fifo_empty;
	logic             fifo_pkt_avail;
	logic             fifo_pop;

	frame_if tx_bus (.clk_i(GMII_GTX_CLK_int));

	//////////////////////////////////////////////////////////////////////
	// ADC sample path
	//////////////////////////////////////////////////////////////////////

	adc_sample_fifo adc_sample_fifo_inst (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.data_i           (adc_data_i),
		.we_i             (adc_data_we_i),
		.pop_i            (fifo_pop),
		.head_o           (fifo_head),
		.empty_o          (fifo_empty),
		.pkt_avail_o      (fifo_pkt_avail)
	);

	packet_framer packet_framer_inst (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.head_i           (fifo_head),
		.empty_i          (fifo_empty),
		.pkt_avail_i      (fifo_pkt_avail),
		.pop_o            (fifo_pop),
		.tx               (tx_bus.source)
	);

	// Sink side straight to the pins
	assign tx_data_o      = tx_bus.word.data;
	assign tx_sof_o       = tx_bus.word.flags.sof;
	assign tx_eof_o       = tx_bus.word.flags.eof;
	assign tx_src_rdy_o   = tx_bus.src_rdy;
	assign tx_bus.dst_rdy = tx_dst_rdy_i;

	//////////////////////////////////////////////////////////////////////
	// Link sync monitor
	//////////////////////////////////////////////////////////////////////

	mux_link_sync mux_link_sync_inst (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.mux_in_i         (mux_in_i),
		.sw_i             (sw_i),
		.mux_out_o        (mux_out_o),
		.bitslip_o        (mux_bitslip_o),
		.synced_o         (mux_synced_o)
	);

endmodule

/* tests/tb_soc_top.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_top;

	localparam int PKT           = `SOC_PACKET_WORDS;
	localparam int SYNC_TIMEOUT  = 100;  // Cycles
	localparam int DRAIN_TIMEOUT = 5000;

	logic                   GMII_GTX_CLK_int;
	logic                   dsp_rst;
	logic [`SOC_DATA_W-1:0] adc_data;
	logic                   adc_data_we;
	logic                   tx_dst_rdy;
	logic [`SOC_DATA_W-1:0] tx_data;
	logic                   tx_sof;
	logic                   tx_eof;
	logic                   tx_src_rdy;
	soc_pkg::mux_word_t     mux_in;
	logic [`SOC_MUX_W-2:0]  sw;
	soc_pkg::mux_word_t     mux_out;
	logic                   mux_bitslip;
	logic                   mux_synced;

	// Values applied at the next falling edge
	logic [31:0]            lcg_state;
	int                     bp_pct;    // Chance of a stall, percent
	soc_pkg::mux_word_t     nxt_mux;
	logic [`SOC_MUX_W-2:0]  nxt_sw;
	logic                   wr_pending;
	soc_pkg::sample_t       wr_data;

	//////////////////////////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////////////////////////

	soc_pkg::sample_t       exp_q[$];  // Written, not yet accepted
	int                     total_written;
	int                     pkt_idx;
	int                     pkt_count;
	soc_pkg::frame_word_t   stall_word;
	logic                   stall_valid;
	logic                   hb_known;
	logic                   last_hb;
	logic [1:0]             slip_hist; // Pulses of the last two cycles
	int                     slip_count;

	soc_top dut0 (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.dsp_rst          (dsp_rst),
		.adc_data_i       (adc_data),
		.adc_data_we_i    (adc_data_we),
		.tx_dst_rdy_i     (tx_dst_rdy),
		.tx_data_o        (tx_data),
		.tx_sof_o         (tx_sof),
		.tx_eof_o         (tx_eof),
		.tx_src_rdy_o     (tx_src_rdy),
		.mux_in_i         (mux_in),
		.sw_i             (sw),
		.mux_out_o        (mux_out),
		.mux_bitslip_o    (mux_bitslip),
		.mux_synced_o     (mux_synced)
	);

	initial begin
		GMII_GTX_CLK_int = 1'b0;
		forever #20 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_on_failure();
		$display("Simulation FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		stop_on_failure();
	endtask

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		stop_on_failure();
	endtask

	task automatic check_frame_word(input soc_pkg::frame_word_t got,
			input soc_pkg::frame_word_t exp);
		if (got !== exp) begin
			report_mismatch($sformatf("frame word %h, expected %h (word %0d of packet %0d)",
				got, exp, pkt_idx, pkt_count));
		end
	endtask

	task automatic check_link(input soc_pkg::mux_word_t exp_word, input logic level);
		if (mux_synced !== level) begin
			report_mismatch($sformatf("mux_synced_o is %b, expected %b", mux_synced, level));
		end
		if (mux_out !== exp_word) begin
			report_mismatch($sformatf("mux_out_o is %h, expected %h", mux_out, exp_word));
		end
	endtask

	// One clock: check what the last rising edge produced, then drive
	task automatic advance_cycle();
		soc_pkg::frame_word_t got;
		soc_pkg::frame_word_t exp;
		@(negedge GMII_GTX_CLK_int);
		if (mux_synced) begin
			if (mux_bitslip) begin
				report_error("bitslip pulse while the link is locked");
			end
			// Heartbeat on bit 7, switches below it
			check_link({hb_known ? ~last_hb : mux_out[7], sw}, 1'b1);
			last_hb  = mux_out[7];
			hb_known = 1'b1;
		end else begin
			hb_known = 1'b0;
		end
		if (mux_bitslip) begin
			if (slip_hist != 2'b00) begin
				report_error("bitslip pulses less than three cycles apart");
			end
			slip_count++;
		end
		slip_hist = {slip_hist[0], mux_bitslip};

		tx_dst_rdy  = int'((lcg_next() >> 16) % 32'd100) >= bp_pct;
		mux_in      = nxt_mux;
		sw          = nxt_sw;
		adc_data    = wr_data;
		adc_data_we = wr_pending;

		// Frame outputs are registered, so the new tx_dst_rdy does not move them
		if (tx_src_rdy) begin
			got.flags.rsvd = '0;
			got.flags.sof  = tx_sof;
			got.flags.eof  = tx_eof;
			got.data       = tx_data;
			if (exp_q.size() == 0) begin
				report_error("frame word offered with no sample outstanding");
			end
			// pkt_avail_o lags the count, so one word may still be on its way
			if (pkt_idx == 0 && exp_q.size() < PKT - 1) begin
				report_error($sformatf("packet started with only %0d samples written",
					exp_q.size()));
			end
			exp.flags.rsvd = '0;
			exp.flags.sof  = (pkt_idx == 0);
			exp.flags.eof  = (pkt_idx == PKT - 1);
			exp.data       = exp_q[0];
			if (tx_dst_rdy) begin
				if (stall_valid) begin
					check_frame_word(got, stall_word);
				end
				check_frame_word(got, exp);
				void'(exp_q.pop_front());
				stall_valid = 1'b0;
				pkt_idx     = exp.flags.eof ? 0 : pkt_idx + 1;
				pkt_count   = pkt_count + int'(exp.flags.eof);
			end else begin
				stall_word  = got;
				stall_valid = 1'b1;
			end
		end else if (stall_valid) begin
			report_error("tx_src_rdy_o dropped while a word was stalled");
		end

		if (wr_pending) begin
			exp_q.push_back(wr_data);
			total_written++;
		end
		wr_pending = 1'b0;
	endtask

	task automatic write_samples(input int n);
		for (int i = 0; i < n; i++) begin
			wr_data    = lcg_next();
			wr_pending = 1'b1;
			advance_cycle();
		end
	endtask

	task automatic run_idle(input int n);
		repeat (n) advance_cycle();
	endtask

	task automatic drive_mux(input soc_pkg::mux_word_t value, input int cycles);
		logic hunting;
		logic bad;
		int   slips_before;
		hunting      = !mux_synced && (mux_in != `SOC_SYNC_LOCK);
		bad          = (value != `SOC_SYNC_HUNT) && (value != `SOC_SYNC_LOCK);
		slips_before = slip_count;
		nxt_mux      = value;
		for (int i = 0; i < cycles; i++) begin
			advance_cycle();
			if (hunting && bad && i >= 1) begin
				check_link(`SOC_SYNC_HUNT, 1'b0); // Still training
			end
		end
		if (hunting && bad && cycles >= 4 && slip_count == slips_before) begin
			report_error($sformatf("no bitslip pulse while receiving %h", value));
		end
	endtask

	task automatic wait_sync(input logic level);
		int t;
		t = 0;
		while (mux_synced !== level) begin
			if (t >= SYNC_TIMEOUT) begin
				report_error($sformatf("timeout waiting for mux_synced_o to become %b", level));
			end
			advance_cycle();
			t++;
		end
	endtask

	task automatic drain_frames();
		int t;
		t = 0;
		while (exp_q.size() != total_written % PKT) begin
			if (t >= DRAIN_TIMEOUT) begin
				report_error("timeout waiting for the written packets to leave");
			end
			advance_cycle();
			t++;
		end
	endtask

	initial begin
		string cmd;
		string rest;
		int    fd;
		int    arg_a;
		int    arg_b;
		lcg_state     = 32'd81542;
		dsp_rst       = 1'b1;
		adc_data      = '0;
		adc_data_we   = 1'b0;
		tx_dst_rdy    = 1'b0;
		mux_in        = 8'h00;
		sw            = '0;
		bp_pct        = 0;
		nxt_mux       = 8'h00;
		nxt_sw        = '0;
		wr_pending    = 1'b0;
		wr_data       = '0;
		total_written = 0;
		pkt_idx       = 0;
		pkt_count     = 0;
		stall_valid   = 1'b0;
		hb_known      = 1'b0;
		last_hb       = 1'b0;
		slip_hist     = 2'b00;
		slip_count    = 0;
		repeat (16) @(negedge GMII_GTX_CLK_int);
		dsp_rst = 1'b0;
		if (tx_src_rdy !== 1'b0 || mux_bitslip !== 1'b0 || mux_synced !== 1'b0) begin
			report_mismatch("tx_src_rdy_o, mux_bitslip_o or mux_synced_o high after reset");
		end

		fd = $fopen("tests/soc_stim.txt", "r");
		if (fd == 0) begin
			report_error("cannot open tests/soc_stim.txt");
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd[0] == "#") begin
				void'($fgets(rest, fd));
			end else if (cmd == "MUX") begin
				if ($fscanf(fd, "%h %h", arg_a, arg_b) != 2) begin
					report_error("MUX line without value and cycles");
				end
				drive_mux(soc_pkg::mux_word_t'(arg_a), arg_b);
			end else if ($fscanf(fd, "%h", arg_a) != 1) begin
				report_error($sformatf("%s line without its argument", cmd));
			end else if (cmd == "SAMPLES") begin
				write_samples(arg_a);
			end else if (cmd == "BACKPRESSURE") begin
				bp_pct = arg_a;
			end else if (cmd == "SW") begin
				nxt_sw = arg_a[`SOC_MUX_W-2:0];
			end else if (cmd == "EXPECT_SYNC") begin
				wait_sync(arg_a[0]);
			end else if (cmd == "IDLE") begin
				run_idle(arg_a);
			end else begin
				report_error($sformatf("unknown command %s in the stimulus file", cmd));
			end
		end
		$fclose(fd);

		drain_frames();
		run_idle(20); // No stray words after the last packet
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* tests/soc_stim.txt */
# Columns: command, then its arguments. All numbers are hex.
# SAMPLES n | BACKPRESSURE pct | MUX value cycles | SW value | EXPECT_SYNC level | IDLE cycles
BACKPRESSURE 0
SAMPLES 64
IDLE 3c
SAMPLES 40
IDLE c8
SAMPLES 100
IDLE 28
BACKPRESSURE 28
SAMPLES 180
IDLE 64
SW 55
MUX 3c c
MUX 01 3
MUX 81 1
EXPECT_SYNC 1
SW 2a
IDLE 8
MUX 05 1
MUX 85 1
MUX 05 1
MUX 85 1
EXPECT_SYNC 1
MUX 05 6
EXPECT_SYNC 0

/* sim.f */
+incdir+include
src/soc_pkg.sv
src/frame_if.sv
src/adc_sample_fifo.sv
src/packet_framer.sv
src/mux_link_sync.sv
src/soc_top.sv
tests/tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_top

sources:
  - include_dirs:
      - include
    files:
      - src/soc_pkg.sv
      - src/frame_if.sv
      - src/adc_sample_fifo.sv
      - src/packet_framer.sv
      - src/mux_link_sync.sv
      - src/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_soc_top.sv
